// ==== verilog.f ====
glay_mem_pkg.sv
sync_fifo.sv
request_arbiter.sv
scratch_memory.sv
response_distributor.sv
memory_channel_top.sv
tb_checker.sv
tb_memory_channel.sv

// ==== tb_memory_channel.sv ====
`timescale 1ns/1ps

module tb_memory_channel;

  import glay_mem_pkg::*;

  localparam int NUM_REQUESTORS  = 4;
  localparam int STIM_DEPTH      = 512;
  localparam int ENTRY_W         = 2 + ADDR_WIDTH + DATA_WIDTH;
  // 288 + 64 + 8 + 30 requests over all tests
  localparam int TOTAL_REQUESTS  = 390;
  localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * 40 + 2000;

  logic                      ap_clk;
  logic                      areset_control;
  logic [NUM_REQUESTORS-1:0] request_valid;
  mem_op_t                   request_op [NUM_REQUESTORS-1:0];
  logic [NUM_REQUESTORS-1:0] request_broadcast;
  logic [ADDR_WIDTH-1:0]     request_address [NUM_REQUESTORS-1:0];
  logic [DATA_WIDTH-1:0]     request_data [NUM_REQUESTORS-1:0];
  logic [NUM_REQUESTORS-1:0] request_grant;
  logic [NUM_REQUESTORS-1:0] response_rd_en;
  logic [NUM_REQUESTORS-1:0] response_valid;
  route_t                    response_route;
  logic [ADDR_WIDTH-1:0]     response_address;
  logic [DATA_WIDTH-1:0]     response_data;
  logic                      fifo_setup_signal;
  logic                      response_full;
  logic                      response_empty;
  logic                      response_prog_full;

  // Per-requestor stimulus rings and the shadow memory
  logic [ENTRY_W-1:0]        stim_mem [NUM_REQUESTORS][STIM_DEPTH];
  int                        stim_head [NUM_REQUESTORS];
  int                        stim_tail [NUM_REQUESTORS];
  logic [DATA_WIDTH-1:0]     shadow_mem [2**ADDR_WIDTH];
  logic [31:0]               rng_state = 32'd46415;
  logic                      rd_en_random;
  logic [NUM_REQUESTORS-1:0] rd_en_hold;
  logic                      expect_valid;
  mem_response_t             expect_response;
  int                        grant_count;
  int                        tb_errors;
  int                        error_count;
  int                        check_count;
  logic [NUM_REQUESTORS-1:0] waiting;

  memory_channel_top #(
    .NUM_REQUESTORS      (NUM_REQUESTORS),
    .RESPONSE_FIFO_DEPTH (16),
    .RESPONSE_PROG_THRESH(10),
    .REQUEST_FIFO_DEPTH  (8)
  ) u_dut (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .request_valid     (request_valid),
    .request_op        (request_op),
    .request_broadcast (request_broadcast),
    .request_address   (request_address),
    .request_data      (request_data),
    .request_grant     (request_grant),
    .response_rd_en    (response_rd_en),
    .response_valid    (response_valid),
    .response_route    (response_route),
    .response_address  (response_address),
    .response_data     (response_data),
    .fifo_setup_signal (fifo_setup_signal),
    .response_full     (response_full),
    .response_empty    (response_empty),
    .response_prog_full(response_prog_full)
  );

  tb_checker #(
    .NUM_REQUESTORS(NUM_REQUESTORS)
  ) u_checker (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .response_valid  (response_valid),
    .response_route  (response_route),
    .response_address(response_address),
    .response_data   (response_data),
    .expect_valid    (expect_valid),
    .expect_response (expect_response),
    .error_count     (error_count),
    .check_count     (check_count),
    .waiting         (waiting)
  );

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Reads see every write granted before them
  function automatic mem_response_t reference_step(input int requestor, input mem_op_t op,
      input logic broadcast, input logic [ADDR_WIDTH-1:0] address,
      input logic [DATA_WIDTH-1:0] data);
    mem_response_t result;
    result.route = '0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (broadcast || i == requestor) begin
        result.route[i] = 1'b1;
      end
    end
    if (op == MEM_OP_WRITE) begin
      shadow_mem[address] = data;
    end
    result.address = address;
    result.data    = shadow_mem[address];
    return result;
  endfunction

  task automatic push_request(input int requestor, input mem_op_t op, input logic broadcast,
      input logic [ADDR_WIDTH-1:0] address, input logic [DATA_WIDTH-1:0] data);
    stim_mem[requestor][stim_tail[requestor] % STIM_DEPTH] = {op, broadcast, address, data};
    stim_tail[requestor] = stim_tail[requestor] + 1;
  endtask

  task automatic check_condition(input logic ok, input string what);
    if (!ok) begin
      $display("ERROR %0t: %s", $time, what);
      tb_errors = tb_errors + 1;
    end
  endtask

  // Idle means no stimulus left, no request held and no response owed
  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge ap_clk);
      busy = (request_valid != '0) || expect_valid || (waiting != '0);
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        if (stim_head[i] != stim_tail[i]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int errors_now;
    errors_now = error_count + tb_errors - errors_before;
    if (errors_now == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors_now);
    end
  endtask

  // --------------------
  // Requestor models
  // --------------------
  always @(posedge ap_clk) begin : requestor_models
    logic [ENTRY_W-1:0] entry;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (areset_control) begin
        request_valid[i] <= 1'b0;
      end else if (!request_valid[i] || request_grant[i]) begin
        if (stim_head[i] != stim_tail[i]) begin
          entry = stim_mem[i][stim_head[i] % STIM_DEPTH];
          request_valid[i]     <= 1'b1;
          request_op[i]        <= mem_op_t'(entry[ENTRY_W-1]);
          request_broadcast[i] <= entry[ENTRY_W-2];
          request_address[i]   <= entry[DATA_WIDTH +: ADDR_WIDTH];
          request_data[i]      <= entry[DATA_WIDTH-1:0];
          stim_head[i]         <= stim_head[i] + 1;
        end else begin
          request_valid[i] <= 1'b0;
        end
      end
    end
  end

  always @(posedge ap_clk) begin : read_enable_driver
    if (areset_control) begin
      response_rd_en <= '0;
    end else if (rd_en_random) begin
      // High about three cycles in four
      response_rd_en <= (NUM_REQUESTORS'(next_random()) | NUM_REQUESTORS'(next_random())) &
                        ~rd_en_hold;
    end else begin
      response_rd_en <= ~rd_en_hold;
    end
  end

  // Grant order fixes the memory order
  always @(posedge ap_clk) begin : reference_model
    mem_response_t expected;
    if (areset_control) begin
      expect_valid <= 1'b0;
      grant_count  <= 0;
    end else begin
      expect_valid <= 1'b0;
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        if (request_grant[i]) begin
          expected = reference_step(i, request_op[i], request_broadcast[i],
                                    request_address[i], request_data[i]);
          grant_count <= grant_count + 1;
          if (request_op[i] == MEM_OP_READ) begin
            expect_valid    <= 1'b1;
            expect_response <= expected;
          end
        end
      end
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main_sequence
    int                    errors_before;
    int                    stall_grants;
    int                    cycles;
    logic [ADDR_WIDTH-1:0] address;
    areset_control    = 1'b1;
    request_valid     = '0;
    request_broadcast = '0;
    response_rd_en    = '0;
    rd_en_random      = 1'b0;
    rd_en_hold        = '0;
    tb_errors         = 0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      request_op[i]      = MEM_OP_READ;
      request_address[i] = '0;
      request_data[i]    = '0;
      stim_head[i]       = 0;
      stim_tail[i]       = 0;
    end
    repeat (16) @(posedge ap_clk);
    areset_control <= 1'b0;

    // Reset state and setup level
    errors_before = 0;
    @(posedge ap_clk);
    check_condition(fifo_setup_signal, "fifo_setup_signal was low right after reset");
    while (fifo_setup_signal) begin
      check_condition(response_valid == '0, "response_valid rose during setup");
      @(posedge ap_clk);
    end
    check_condition(response_empty, "response_empty was low after setup");
    report_test("5 reset and setup", errors_before);

    // Fill every address from one requestor, then write and read back
    errors_before = error_count + tb_errors;
    @(negedge ap_clk);
    for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
      push_request(0, MEM_OP_WRITE, 1'b0, ADDR_WIDTH'(a), next_random() ^ (a * 32'h0101_0101));
    end
    for (int k = 0; k < 16; k++) begin
      address = ADDR_WIDTH'(next_random());
      push_request(0, MEM_OP_WRITE, 1'b0, address, next_random());
      push_request(0, MEM_OP_READ, 1'b0, address, '0);
    end
    wait_idle();
    report_test("1 write then read, one requestor", errors_before);

    // All requestors at once with random mix and read enables
    errors_before = error_count + tb_errors;
    @(negedge ap_clk);
    rd_en_random = 1'b1;
    for (int k = 0; k < 16; k++) begin
      for (int r = 0; r < NUM_REQUESTORS; r++) begin
        address = ADDR_WIDTH'(next_random());
        if ((next_random() & 32'h3) == 0) begin
          push_request(r, MEM_OP_WRITE, 1'b0, address, next_random());
        end else begin
          push_request(r, MEM_OP_READ, 1'b0, address, '0);
        end
      end
    end
    wait_idle();
    report_test("2 all requestors", errors_before);

    errors_before = error_count + tb_errors;
    @(negedge ap_clk);
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      push_request(r, MEM_OP_READ, 1'b1, ADDR_WIDTH'(next_random()), '0);
      push_request(r, MEM_OP_READ, 1'b1, ADDR_WIDTH'(next_random()), '0);
    end
    wait_idle();
    report_test("3 broadcast reads", errors_before);

    // Requestor 1 stops reading until back-pressure reaches the arbiter
    errors_before = error_count + tb_errors;
    @(negedge ap_clk);
    rd_en_random = 1'b0;
    rd_en_hold   = NUM_REQUESTORS'(2);
    for (int k = 0; k < 30; k++) begin
      push_request(1, MEM_OP_READ, 1'b0, ADDR_WIDTH'(next_random()), '0);
    end
    cycles = 0;
    while (!response_prog_full && cycles < 400) begin
      @(posedge ap_clk);
      cycles = cycles + 1;
    end
    check_condition(response_prog_full, "response_prog_full never rose during the stall");
    check_condition(!response_empty, "response_empty was high with responses held");
    for (int c = 0; c < 40; c++) begin
      @(posedge ap_clk);
      check_condition(!response_full, "response_full rose while reads were held back");
    end
    stall_grants = grant_count;
    for (int c = 0; c < 40; c++) begin
      @(posedge ap_clk);
      check_condition(!response_full, "response_full rose while reads were held back");
    end
    check_condition(grant_count == stall_grants, "grants went on while the FIFO was held");
    check_condition(request_valid[1], "requestor 1 was never held back by the full queue");
    @(negedge ap_clk);
    rd_en_hold = '0;
    wait_idle();
    report_test("4 read enable stall", errors_before);

    $display("Done: %0d response checks, %0d errors", check_count, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    if (fifo_setup_signal) begin
      $display("fifo_setup_signal never fell");
    end
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (stim_head[i] != stim_tail[i] || request_valid[i]) begin
        $display("Requestor %0d was still waiting for a grant", i);
      end
      if (waiting[i]) begin
        $display("Response queue of requestor %0d was still waiting for data", i);
      end
    end
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_memory_channel

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker #(
  parameter int NUM_REQUESTORS = 4,
  parameter int QUEUE_DEPTH    = 512
) (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic [NUM_REQUESTORS-1:0]           response_valid,
  input  glay_mem_pkg::route_t                response_route,
  input  logic [glay_mem_pkg::ADDR_WIDTH-1:0] response_address,
  input  logic [glay_mem_pkg::DATA_WIDTH-1:0] response_data,
  input  logic                                expect_valid,
  input  glay_mem_pkg::mem_response_t         expect_response,
  output int                                  error_count,
  output int                                  check_count,
  output logic [NUM_REQUESTORS-1:0]           waiting
);

  import glay_mem_pkg::*;

  // One expected queue per requestor, kept as a ring
  mem_response_t expect_mem [NUM_REQUESTORS][QUEUE_DEPTH];
  int            head [NUM_REQUESTORS];
  int            tail [NUM_REQUESTORS];

  // --------------------
  // Compare on the falling edge, DUT outputs are settled there
  // --------------------
  always @(negedge ap_clk) begin : compare_responses
    mem_response_t front;
    if (areset_control) begin
      error_count = 0;
      check_count = 0;
      waiting     = '0;
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        head[i] = 0;
        tail[i] = 0;
      end
    end else begin
      // New expectation goes to every routed requestor
      if (expect_valid) begin
        for (int i = 0; i < NUM_REQUESTORS; i++) begin
          if (expect_response.route[i]) begin
            expect_mem[i][tail[i] % QUEUE_DEPTH] = expect_response;
            tail[i] = tail[i] + 1;
          end
        end
      end
      // All routed requestors strobe together, nobody else
      if (response_valid != '0 && response_valid != response_route[NUM_REQUESTORS-1:0]) begin
        $display("ERROR %0t: response strobes %b differ from route %b", $time,
                 response_valid, response_route[NUM_REQUESTORS-1:0]);
        error_count = error_count + 1;
      end
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        if (response_valid[i]) begin
          if (head[i] == tail[i]) begin
            $display("Requestor %0d received a response at %0t that it never asked for",
                     i, $time);
            error_count = error_count + 1;
          end else begin
            front   = expect_mem[i][head[i] % QUEUE_DEPTH];
            head[i] = head[i] + 1;
            check_count = check_count + 1;
            if (response_route !== front.route || response_address !== front.address ||
                response_data !== front.data) begin
              $display("ERROR %0t: requestor %0d got route %h addr %h data %h, expected %h %h %h",
                       $time, i, response_route, response_address, response_data,
                       front.route, front.address, front.data);
              error_count = error_count + 1;
            end
          end
        end
        waiting[i] = (head[i] != tail[i]);
      end
    end
  end

endmodule : tb_checker

// ==== memory_channel_top.sv ====
`timescale 1ns/1ps

module memory_channel_top #(
  parameter int NUM_REQUESTORS       = 4,
  parameter int RESPONSE_FIFO_DEPTH  = 16,
  parameter int RESPONSE_PROG_THRESH = 10,
  parameter int REQUEST_FIFO_DEPTH   = 8
) (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic [NUM_REQUESTORS-1:0]           request_valid,
  input  glay_mem_pkg::mem_op_t               request_op [NUM_REQUESTORS-1:0],
  input  logic [NUM_REQUESTORS-1:0]           request_broadcast,
  input  logic [glay_mem_pkg::ADDR_WIDTH-1:0] request_address [NUM_REQUESTORS-1:0],
  input  logic [glay_mem_pkg::DATA_WIDTH-1:0] request_data [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0]           request_grant,
  input  logic [NUM_REQUESTORS-1:0]           response_rd_en,
  output logic [NUM_REQUESTORS-1:0]           response_valid,
  output glay_mem_pkg::route_t                response_route,
  output logic [glay_mem_pkg::ADDR_WIDTH-1:0] response_address,
  output logic [glay_mem_pkg::DATA_WIDTH-1:0] response_data,
  output logic                                fifo_setup_signal,
  output logic                                response_full,
  output logic                                response_empty,
  output logic                                response_prog_full
);

  import glay_mem_pkg::*;

  logic          mem_request_valid;
  mem_request_t  mem_request;
  logic          request_queue_full;
  logic          response_in_valid;
  mem_response_t response_in;
  mem_response_t response_out;

  request_arbiter #(
    .NUM_REQUESTORS(NUM_REQUESTORS)
  ) u_request_arbiter (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .request_valid     (request_valid),
    .request_op        (request_op),
    .request_broadcast (request_broadcast),
    .request_address   (request_address),
    .request_data      (request_data),
    .request_queue_full(request_queue_full),
    .request_grant     (request_grant),
    .mem_request_valid (mem_request_valid),
    .mem_request       (mem_request)
  );

  scratch_memory #(
    .REQUEST_FIFO_DEPTH(REQUEST_FIFO_DEPTH)
  ) u_scratch_memory (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .mem_request_valid (mem_request_valid),
    .mem_request       (mem_request),
    .response_prog_full(response_prog_full),
    .request_queue_full(request_queue_full),
    .response_in_valid (response_in_valid),
    .response_in       (response_in)
  );

  response_distributor #(
    .NUM_REQUESTORS  (NUM_REQUESTORS),
    .FIFO_WRITE_DEPTH(RESPONSE_FIFO_DEPTH),
    .PROG_THRESH     (RESPONSE_PROG_THRESH)
  ) u_response_distributor (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .response_in_valid (response_in_valid),
    .response_in       (response_in),
    .response_rd_en    (response_rd_en),
    .response_valid    (response_valid),
    .response_out      (response_out),
    .fifo_setup_signal (fifo_setup_signal),
    .response_full     (response_full),
    .response_empty    (response_empty),
    .response_prog_full(response_prog_full)
  );

  // Shared response fields seen by all requestors
  assign response_route   = response_out.route;
  assign response_address = response_out.address;
  assign response_data    = response_out.data;

endmodule : memory_channel_top

// ==== response_distributor.sv ====
`timescale 1ns/1ps

module response_distributor #(
  parameter int NUM_REQUESTORS   = 4,
  parameter int FIFO_WRITE_DEPTH = 16,
  parameter int PROG_THRESH      = 10
) (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  logic                        response_in_valid,
  input  glay_mem_pkg::mem_response_t response_in,
  input  logic [NUM_REQUESTORS-1:0]   response_rd_en,
  output logic [NUM_REQUESTORS-1:0]   response_valid,
  output glay_mem_pkg::mem_response_t response_out,
  output logic                        fifo_setup_signal,
  output logic                        response_full,
  output logic                        response_empty,
  output logic                        response_prog_full
);

  import glay_mem_pkg::*;

  // --------------------
  // Input stage
  // --------------------
  mem_response_t response_in_reg;
  logic          response_in_valid_reg;

  // --------------------
  // Response FIFO
  // --------------------
  mem_response_t             fifo_dout;
  logic                      fifo_wr_en;
  logic                      fifo_rd_en;
  logic                      fifo_full;
  logic                      fifo_empty;
  logic                      fifo_valid;
  logic                      fifo_prog_full;
  logic                      fifo_wr_rst_busy;
  logic                      fifo_rd_rst_busy;

  // --------------------
  // Read enable masking
  // --------------------
  logic [NUM_REQUESTORS-1:0] head_route;
  logic [NUM_REQUESTORS-1:0] rd_en_reg;
  logic [NUM_REQUESTORS-1:0] rd_mask_int;
  logic [NUM_REQUESTORS-1:0] rd_mask_reg;
  logic                      head_ready;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_in_valid_reg <= 1'b0;
    end else begin
      response_in_valid_reg <= response_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    response_in_reg <= response_in;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rd_en_reg   <= '0;
      rd_mask_reg <= '0;
    end else begin
      rd_en_reg   <= response_rd_en;
      rd_mask_reg <= rd_mask_int;
    end
  end

  assign head_route  = fifo_dout.route[NUM_REQUESTORS-1:0];
  // No mask builds up without a head
  assign rd_mask_int = rd_en_reg & head_route & {NUM_REQUESTORS{fifo_valid}};

  // Every routed requestor must be reading before the head leaves
  assign head_ready = (rd_mask_reg == head_route);

  // Unrouted answers have nobody to go to
  assign fifo_wr_en = response_in_valid_reg & (|response_in_reg.route[NUM_REQUESTORS-1:0]);
  assign fifo_rd_en = fifo_valid & head_ready;

  sync_fifo #(
    .payload_t  (mem_response_t),
    .DEPTH      (FIFO_WRITE_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) u_response_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (response_in_reg),
    .wr_en         (fifo_wr_en),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .full          (fifo_full),
    .empty         (fifo_empty),
    .valid         (fifo_valid),
    .prog_full     (fifo_prog_full),
    .wr_rst_busy   (fifo_wr_rst_busy),
    .rd_rst_busy   (fifo_rd_rst_busy)
  );

  // --------------------
  // Fan out
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_valid <= '0;
    end else begin
      response_valid <= fifo_rd_en ? head_route : '0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (fifo_rd_en) begin
      response_out <= fifo_dout;
    end
  end

  // Setup level and status
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_setup_signal  <= 1'b1;
      response_full      <= 1'b0;
      response_empty     <= 1'b1;
      response_prog_full <= 1'b0;
    end else begin
      fifo_setup_signal  <= fifo_wr_rst_busy | fifo_rd_rst_busy;
      response_full      <= fifo_full;
      response_empty     <= fifo_empty;
      response_prog_full <= fifo_prog_full;
    end
  end

endmodule : response_distributor

// ==== scratch_memory.sv ====
`timescale 1ns/1ps

module scratch_memory #(
  parameter int REQUEST_FIFO_DEPTH = 8
) (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  logic                        mem_request_valid,
  input  glay_mem_pkg::mem_request_t  mem_request,
  input  logic                        response_prog_full,
  output logic                        request_queue_full,
  output logic                        response_in_valid,
  output glay_mem_pkg::mem_response_t response_in
);

  import glay_mem_pkg::*;

  mem_request_t          req_head;
  mem_request_t          stage_request;
  logic                  stage_valid;
  logic                  req_pop;
  logic                  req_full;
  logic                  req_empty;
  logic                  req_valid;
  logic                  req_almost_full;
  logic                  req_wr_rst_busy;
  logic                  req_rd_rst_busy;
  logic [DATA_WIDTH-1:0] mem_array [2**ADDR_WIDTH];

  // --------------------
  // Request queue
  // --------------------
  // Threshold one below depth covers the strobe already in flight
  sync_fifo #(
    .payload_t  (mem_request_t),
    .DEPTH      (REQUEST_FIFO_DEPTH),
    .PROG_THRESH(REQUEST_FIFO_DEPTH - 1)
  ) u_request_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (mem_request),
    .wr_en         (mem_request_valid),
    .rd_en         (req_pop),
    .dout          (req_head),
    .full          (req_full),
    .empty         (req_empty),
    .valid         (req_valid),
    .prog_full     (req_almost_full),
    .wr_rst_busy   (req_wr_rst_busy),
    .rd_rst_busy   (req_rd_rst_busy)
  );

  assign request_queue_full = req_full | req_almost_full | req_wr_rst_busy;

  // Writes drain freely, reads wait for room downstream
  assign req_pop = req_valid & ~req_empty & ~req_rd_rst_busy &
                   ((req_head.op == MEM_OP_WRITE) | ~response_prog_full);

  // --------------------
  // Execute stage
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      stage_valid       <= 1'b0;
      response_in_valid <= 1'b0;
    end else begin
      stage_valid       <= req_pop;
      response_in_valid <= stage_valid & (stage_request.op == MEM_OP_READ);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (req_pop) begin
      stage_request <= req_head;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (stage_valid && stage_request.op == MEM_OP_WRITE) begin
      mem_array[stage_request.address] <= stage_request.data;
    end
  end

  // Read answer, two cycles after the pop
  always_ff @(posedge ap_clk) begin
    if (stage_valid && stage_request.op == MEM_OP_READ) begin
      response_in.route   <= stage_request.route;
      response_in.address <= stage_request.address;
      response_in.data    <= mem_array[stage_request.address];
    end
  end

endmodule : scratch_memory

// ==== request_arbiter.sv ====
`timescale 1ns/1ps

module request_arbiter #(
  parameter int NUM_REQUESTORS = 4
) (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  logic [NUM_REQUESTORS-1:0]             request_valid,
  input  glay_mem_pkg::mem_op_t                 request_op [NUM_REQUESTORS-1:0],
  input  logic [NUM_REQUESTORS-1:0]             request_broadcast,
  input  logic [glay_mem_pkg::ADDR_WIDTH-1:0]   request_address [NUM_REQUESTORS-1:0],
  input  logic [glay_mem_pkg::DATA_WIDTH-1:0]   request_data [NUM_REQUESTORS-1:0],
  input  logic                                  request_queue_full,
  output logic [NUM_REQUESTORS-1:0]             request_grant,
  output logic                                  mem_request_valid,
  output glay_mem_pkg::mem_request_t            mem_request
);

  import glay_mem_pkg::*;

  localparam int PTR_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

  logic [NUM_REQUESTORS-1:0] eligible;
  logic [PTR_W-1:0]          rr_ptr;
  logic [PTR_W-1:0]          winner;
  logic                      found;
  logic                      grant_now;
  route_t                    next_route;

  // A requestor granted last cycle still shows its level for one edge
  assign eligible  = request_valid & ~request_grant;
  assign grant_now = found & ~request_queue_full;

  // --------------------
  // Round-robin search
  // --------------------
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = '0;
    for (int k = 0; k < NUM_REQUESTORS; k++) begin
      idx = (int'(rr_ptr) + k) % NUM_REQUESTORS;
      if (!found && eligible[idx]) begin
        found  = 1'b1;
        winner = PTR_W'(idx);
      end
    end
  end

  // Route stamp, one-hot winner or every requestor
  always_comb begin
    next_route = '0;
    if (request_broadcast[winner]) begin
      next_route[NUM_REQUESTORS-1:0] = '1;
    end else begin
      next_route[winner] = 1'b1;
    end
  end

  // --------------------
  // Grant and strobe
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_grant     <= '0;
      mem_request_valid <= 1'b0;
      rr_ptr            <= '0;
    end else begin
      request_grant     <= '0;
      mem_request_valid <= grant_now;
      if (grant_now) begin
        request_grant[winner] <= 1'b1;
        rr_ptr <= (winner == PTR_W'(NUM_REQUESTORS - 1)) ? '0 : winner + 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (grant_now) begin
      mem_request.op        <= request_op[winner];
      mem_request.broadcast <= request_broadcast[winner];
      mem_request.address   <= request_address[winner];
      mem_request.data      <= request_data[winner];
      mem_request.route     <= next_route;
    end
  end

endmodule : request_arbiter

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t   = logic [31:0],
  parameter int  DEPTH       = 16,
  parameter int  PROG_THRESH = 10
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  payload_t din,
  input  logic     wr_en,
  input  logic     rd_en,
  output payload_t dout,
  output logic     full,
  output logic     empty,
  output logic     valid,
  output logic     prog_full,
  output logic     wr_rst_busy,
  output logic     rd_rst_busy
);

  localparam int PTR_W             = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W             = $clog2(DEPTH + 1);
  localparam int RESET_BUSY_CYCLES = 4;

  payload_t         fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [2:0]       busy_count;
  logic             busy;
  logic             do_write;
  logic             do_read;

  // --------------------
  // Reset busy window
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_count <= 3'(RESET_BUSY_CYCLES);
    end else if (busy_count != 3'd0) begin
      busy_count <= busy_count - 3'd1;
    end
  end

  assign busy        = (busy_count != 3'd0);
  assign wr_rst_busy = busy;
  assign rd_rst_busy = busy;

  // Requests are dropped while busy or at the limits
  assign do_write = wr_en & ~full & ~busy;
  assign do_read  = rd_en & ~empty & ~busy;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      fifo_mem[wr_ptr] <= din;
    end
  end

  // First word falls through, head shown without a read
  assign dout      = fifo_mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign valid     = ~empty;
  assign prog_full = (count >= CNT_W'(PROG_THRESH));

endmodule : sync_fifo

// ==== glay_mem_pkg.sv ====
package glay_mem_pkg;

  // --------------------
  // Channel dimensions
  // --------------------
  parameter int MAX_REQUESTORS = 8;
  parameter int ADDR_WIDTH     = 8;
  parameter int DATA_WIDTH     = 32;

  // --------------------
  // Request opcode
  // --------------------
  typedef enum logic {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_t;

  // One bit per requestor, all low bits set for a broadcast
  typedef logic [MAX_REQUESTORS-1:0] route_t;

  // --------------------
  // Request packet
  // --------------------
  // 1 + 1 + 8 + 32 + 8 = 50 bits
  typedef struct packed {
    mem_op_t               op;
    logic                  broadcast;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] data;
    route_t                route;
  } mem_request_t;

  // --------------------
  // Response packet
  // --------------------
  // 8 + 8 + 32 = 48 bits, buffered and fanned out by the distributor
  typedef struct packed {
    route_t                route;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] data;
  } mem_response_t;

endpackage : glay_mem_pkg
